// ==== hdl/spi_ctrl_pkg.sv ====
`default_nettype none

package spi_ctrl_pkg;

    localparam int WORD_W      = 32;
    localparam int LEN_W       = 16;   // data phase length in bits
    localparam int PHASE_LEN_W = 6;    // cmd and addr length in bits

    typedef enum logic [1:0]
    {
        OP_RD,
        OP_WR,
        OP_QRD,
        OP_QWR
    } spi_op_e;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_CMD,
        ST_ADDR,
        ST_DATA_TX,
        ST_DATA_RX,
        ST_WAIT_EDGE
    } spi_state_e;

    typedef struct packed
    {
        spi_op_e                op;
        logic [WORD_W-1:0]      cmd;
        logic [PHASE_LEN_W-1:0] cmd_len;    // top bits of cmd to send
        logic [WORD_W-1:0]      addr;
        logic [PHASE_LEN_W-1:0] addr_len;
        logic [LEN_W-1:0]       data_len;
    } spi_xfer_t;

endpackage

`default_nettype wire

// ==== hdl/spi_pad_pkg.sv ====
`default_nettype none

package spi_pad_pkg;

    typedef enum logic [1:0]
    {
        LANE_STD     = 2'b00,
        LANE_QUAD_TX = 2'b01,
        LANE_QUAD_RX = 2'b10
    } spi_lane_e;

    typedef struct packed
    {
        logic       sclk;
        logic [3:0] sdo;    // sdo[0] is the standard mode line
        spi_lane_e  mode;
    } spi_pad_out_t;

endpackage

`default_nettype wire

// ==== hdl/spi_xfer_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_xfer_regs #(
    parameter int CLK_DIV_W = 8,
    parameter int N_CS      = 4
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          req,
    output logic                         ack,
    input  wire spi_ctrl_pkg::spi_xfer_t xfer_in,
    input  wire [CLK_DIV_W-1:0]          clk_div_in,
    input  wire [N_CS-1:0]               cs_mask_in,
    input  wire                          done,
    output logic                         start,
    output spi_ctrl_pkg::spi_xfer_t      xfer_q,
    output logic [CLK_DIV_W-1:0]         clk_div_q,
    output logic [N_CS-1:0]              cs_mask_q
);

    logic busy;
    logic accept;

    assign accept = req && !busy && !ack;   // new request while idle

    always_ff @(posedge clk, negedge rstn)
    begin
        if (!rstn)
        begin
            busy  <= 1'b0;
            ack   <= 1'b0;
            start <= 1'b0;
        end
        else
        begin
            start <= accept;
            if (accept)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
            if (done)
                ack <= 1'b1;
            else if (!req)
                ack <= 1'b0;                // host released req
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            xfer_q    <= xfer_in;
            clk_div_q <= clk_div_in;
            cs_mask_q <= cs_mask_in;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_clkgen #(
    parameter int CLK_DIV_W = 8
) (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 en,
    input  wire [CLK_DIV_W-1:0] clk_div,
    output logic                sclk,
    output logic                rise,
    output logic                fall
);

    logic [CLK_DIV_W-1:0] cnt;
    logic                 expire;

    assign expire = cnt == '0;

    // a high phase always completes, so sclk settles low once disabled
    assign rise = en && !sclk && expire;
    assign fall = sclk && expire;

    always_ff @(posedge clk, negedge rstn)
    begin
        if (!rstn)
        begin
            cnt  <= '0;
            sclk <= 1'b0;
        end
        else if (rise || fall)
        begin
            cnt  <= clk_div;
            sclk <= !sclk;
        end
        else if (en || sclk)
        begin
            cnt <= cnt - 1'b1;
        end
        else
        begin
            cnt <= clk_div;         // parked low, restart a full low phase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_shift_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_shift_tx (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            en,
    input  wire                            fall,
    input  wire                            quad,
    input  wire                            load,
    input  wire [spi_ctrl_pkg::WORD_W-1:0] load_word,
    input  wire [spi_ctrl_pkg::LEN_W-1:0]  bit_count,
    output logic                           need_word,
    input  wire                            word_valid,
    output logic [3:0]                     sdo,
    output logic                           done
);

    localparam int LW    = spi_ctrl_pkg::LEN_W;
    localparam int POS_W = $clog2(spi_ctrl_pkg::WORD_W);

    logic [spi_ctrl_pkg::WORD_W-1:0] shreg;
    logic [LW-1:0]                   cnt;
    logic [LW-1:0]                   step;
    logic [POS_W-1:0]                wpos;
    logic [POS_W-1:0]                wpos_next;
    logic                            shift;

    assign step      = {{(LW-3){1'b0}}, quad, 1'b0, !quad};     // 4 in quad, else 1
    assign wpos_next = wpos + step[POS_W-1:0];                  // wraps at word end
    assign shift     = en && fall && cnt != '0;
    assign done      = en && fall && cnt <= step;               // last bits leave now
    assign sdo       = quad ? shreg[spi_ctrl_pkg::WORD_W-1 -: 4]
                            : {3'b000, shreg[spi_ctrl_pkg::WORD_W-1]};

    always_ff @(posedge clk, negedge rstn)
    begin
        if (!rstn)
        begin
            shreg     <= '0;
            cnt       <= '0;
            wpos      <= '0;
            need_word <= 1'b0;
        end
        else if (load)
        begin
            shreg     <= load_word;
            cnt       <= bit_count;
            wpos      <= '0;
            need_word <= 1'b0;
        end
        else if (need_word)
        begin
            if (word_valid)
            begin
                shreg     <= load_word;
                need_word <= 1'b0;
            end
        end
        else if (shift)
        begin
            shreg     <= quad ? shreg << 4 : shreg << 1;
            cnt       <= cnt - step;
            wpos      <= wpos_next;
            need_word <= wpos_next == '0 && cnt > step;     // word empty, more to go
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_shift_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_shift_rx (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            en,
    input  wire                            rise,
    input  wire                            quad,
    input  wire                            load,
    input  wire [spi_ctrl_pkg::LEN_W-1:0]  bit_count,
    input  wire [3:0]                      sdi,
    output logic [spi_ctrl_pkg::WORD_W-1:0] rx_data,
    output logic                           rx_valid,
    input  wire                            rx_ready,
    output logic                           full,
    output logic                           done
);

    localparam int W     = spi_ctrl_pkg::WORD_W;
    localparam int LW    = spi_ctrl_pkg::LEN_W;
    localparam int POS_W = $clog2(W);

    logic [W-1:0]     shreg;
    logic [W-1:0]     shreg_next;
    logic [LW-1:0]    cnt;
    logic [LW-1:0]    step;
    logic [POS_W-1:0] wpos;
    logic [POS_W-1:0] wpos_next;
    logic             sample;
    logic             last;

    assign step       = {{(LW-3){1'b0}}, quad, 1'b0, !quad};
    assign shreg_next = quad ? {shreg[W-5:0], sdi} : {shreg[W-2:0], sdi[1]};
    assign wpos_next  = wpos + step[POS_W-1:0];
    assign sample     = en && rise && cnt != '0;
    assign last       = wpos_next == '0 || cnt <= step;   // next sample closes a word
    assign full       = rx_valid && cnt != '0 && last;
    assign done       = cnt == '0;

    always_ff @(posedge clk, negedge rstn)
    begin
        if (!rstn)
        begin
            cnt      <= '0;
            wpos     <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            if (load)
            begin
                cnt  <= bit_count;
                wpos <= '0;
            end
            else if (sample)
            begin
                cnt  <= cnt - step;
                wpos <= wpos_next;
            end
            if (sample && last)
                rx_valid <= 1'b1;
            else if (rx_ready)
                rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load || (sample && last))
            shreg <= '0;                // partial words end up right-aligned
        else if (sample)
            shreg <= shreg_next;
        if (sample && last)
            rx_data <= shreg_next;
    end

endmodule

`default_nettype wire

// ==== hdl/spi_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_sequencer #(
    parameter int N_CS = 4
) (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             start,
    input  wire spi_ctrl_pkg::spi_xfer_t    xfer,
    input  wire [N_CS-1:0]                  cs_mask,
    output logic                            done,
    output logic                            clk_en,
    input  wire                             fall,
    output logic                            tx_load,
    output logic                            tx_en,
    output logic [spi_ctrl_pkg::WORD_W-1:0] tx_word,
    output logic [spi_ctrl_pkg::LEN_W-1:0]  tx_count,
    input  wire                             tx_need_word,
    input  wire                             tx_done,
    input  wire [spi_ctrl_pkg::WORD_W-1:0]  tx_data,
    input  wire                             tx_valid,
    output logic                            tx_ready,
    output logic                            rx_load,
    output logic                            rx_en,
    output logic [spi_ctrl_pkg::LEN_W-1:0]  rx_count,
    input  wire                             rx_full,
    input  wire                             rx_done,
    output logic                            quad,
    output spi_pad_pkg::spi_lane_e          mode,
    output logic [N_CS-1:0]                 csn
);

    localparam int LEN_PAD = spi_ctrl_pkg::LEN_W - spi_ctrl_pkg::PHASE_LEN_W;

    spi_ctrl_pkg::spi_state_e state;
    spi_ctrl_pkg::spi_state_e state_next;
    spi_ctrl_pkg::spi_state_e after;
    spi_pad_pkg::spi_lane_e   lane;
    logic                     is_read;
    logic                     advance;
    logic                     tx_first;

    assign is_read = xfer.op == spi_ctrl_pkg::OP_RD || xfer.op == spi_ctrl_pkg::OP_QRD;
    assign quad    = xfer.op == spi_ctrl_pkg::OP_QRD || xfer.op == spi_ctrl_pkg::OP_QWR;
    assign advance = (state == spi_ctrl_pkg::ST_IDLE && start)
                  || ((state == spi_ctrl_pkg::ST_CMD || state == spi_ctrl_pkg::ST_ADDR)
                      && tx_done);
    assign tx_en    = state == spi_ctrl_pkg::ST_CMD || state == spi_ctrl_pkg::ST_ADDR
                   || state == spi_ctrl_pkg::ST_DATA_TX;
    assign rx_en    = state == spi_ctrl_pkg::ST_DATA_RX;
    assign rx_count = xfer.data_len;
    assign csn      = ~(cs_mask & {N_CS{state != spi_ctrl_pkg::ST_IDLE}});

    // following phase, zero length phases skipped
    always_comb
    begin
        after = spi_ctrl_pkg::ST_IDLE;
        if (xfer.data_len != '0)
            after = is_read ? spi_ctrl_pkg::ST_DATA_RX : spi_ctrl_pkg::ST_DATA_TX;
        if (xfer.addr_len != '0 && state != spi_ctrl_pkg::ST_ADDR)
            after = spi_ctrl_pkg::ST_ADDR;
        if (xfer.cmd_len != '0 && state == spi_ctrl_pkg::ST_IDLE)
            after = spi_ctrl_pkg::ST_CMD;
    end

    always_comb
    begin
        state_next = state;
        done       = 1'b0;
        clk_en     = 1'b0;
        tx_load    = 1'b0;
        tx_word    = tx_data;
        tx_count   = xfer.data_len;
        tx_ready   = 1'b0;
        rx_load    = 1'b0;
        if (advance)
        begin
            state_next = after;
            done       = after == spi_ctrl_pkg::ST_IDLE;
            tx_load    = after == spi_ctrl_pkg::ST_CMD || after == spi_ctrl_pkg::ST_ADDR;
            rx_load    = after == spi_ctrl_pkg::ST_DATA_RX;
            if (after == spi_ctrl_pkg::ST_CMD)
            begin
                tx_word  = xfer.cmd;
                tx_count = {{LEN_PAD{1'b0}}, xfer.cmd_len};
            end
            else if (after == spi_ctrl_pkg::ST_ADDR)
            begin
                tx_word  = xfer.addr;
                tx_count = {{LEN_PAD{1'b0}}, xfer.addr_len};
            end
        end
        case (state)
            spi_ctrl_pkg::ST_CMD, spi_ctrl_pkg::ST_ADDR:
                clk_en = 1'b1;
            spi_ctrl_pkg::ST_DATA_TX:
            begin
                clk_en   = !tx_first && !tx_need_word;  // hold sclk low for a word
                tx_ready = tx_first || tx_need_word;
                tx_load  = tx_first && tx_valid;        // first word carries the count
                if (tx_done)
                begin
                    state_next = spi_ctrl_pkg::ST_IDLE;
                    done       = 1'b1;
                end
            end
            spi_ctrl_pkg::ST_DATA_RX:
            begin
                clk_en = !rx_full;
                if (rx_done)
                begin
                    state_next = fall ? spi_ctrl_pkg::ST_IDLE : spi_ctrl_pkg::ST_WAIT_EDGE;
                    done       = fall;
                end
            end
            spi_ctrl_pkg::ST_WAIT_EDGE:
            begin
                if (fall)
                begin
                    state_next = spi_ctrl_pkg::ST_IDLE;
                    done       = 1'b1;
                end
            end
            default:
                clk_en = 1'b0;
        endcase
    end

    always_comb
    begin
        case (state_next)
            spi_ctrl_pkg::ST_CMD, spi_ctrl_pkg::ST_ADDR, spi_ctrl_pkg::ST_DATA_TX:
                lane = quad ? spi_pad_pkg::LANE_QUAD_TX : spi_pad_pkg::LANE_STD;
            spi_ctrl_pkg::ST_DATA_RX, spi_ctrl_pkg::ST_WAIT_EDGE:
                lane = quad ? spi_pad_pkg::LANE_QUAD_RX : spi_pad_pkg::LANE_STD;
            default:
                lane = spi_pad_pkg::LANE_QUAD_RX;
        endcase
    end

    always_ff @(posedge clk, negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= spi_ctrl_pkg::ST_IDLE;
            mode     <= spi_pad_pkg::LANE_QUAD_RX;
            tx_first <= 1'b0;
        end
        else
        begin
            state    <= state_next;
            mode     <= lane;
            tx_first <= (advance && after == spi_ctrl_pkg::ST_DATA_TX) || (tx_first && !tx_valid);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/spi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_master #(
    parameter int CLK_DIV_W = 8,
    parameter int N_CS      = 4
) (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             req,
    output logic                            ack,
    input  wire spi_ctrl_pkg::spi_xfer_t    xfer,
    input  wire [CLK_DIV_W-1:0]             clk_div,
    input  wire [N_CS-1:0]                  cs_mask,
    input  wire [spi_ctrl_pkg::WORD_W-1:0]  tx_data,
    input  wire                             tx_valid,
    output logic                            tx_ready,
    output logic [spi_ctrl_pkg::WORD_W-1:0] rx_data,
    output logic                            rx_valid,
    input  wire                             rx_ready,
    output spi_pad_pkg::spi_pad_out_t       pad_out,
    output logic [N_CS-1:0]                 csn,
    input  wire [3:0]                       sdi
);

    spi_ctrl_pkg::spi_xfer_t          xfer_q;
    logic [CLK_DIV_W-1:0]             clk_div_q;
    logic [N_CS-1:0]                  cs_mask_q;
    logic                             start;
    logic                             done;
    logic                             clk_en;
    logic                             sclk;
    logic                             rise;
    logic                             fall;
    logic                             quad;
    logic                             tx_load;
    logic                             tx_en;
    logic                             tx_need_word;
    logic                             tx_done;
    logic [spi_ctrl_pkg::WORD_W-1:0]  tx_word;
    logic [spi_ctrl_pkg::LEN_W-1:0]   tx_count;
    logic                             rx_load;
    logic                             rx_en;
    logic                             rx_full;
    logic                             rx_done;
    logic [spi_ctrl_pkg::LEN_W-1:0]   rx_count;
    logic [3:0]                       sdo;
    spi_pad_pkg::spi_lane_e           mode;

    spi_xfer_regs #(.CLK_DIV_W(CLK_DIV_W), .N_CS(N_CS)) u_regs (
        .clk(clk), .rstn(rstn), .req(req), .ack(ack),
        .xfer_in(xfer), .clk_div_in(clk_div), .cs_mask_in(cs_mask),
        .done(done), .start(start),
        .xfer_q(xfer_q), .clk_div_q(clk_div_q), .cs_mask_q(cs_mask_q)
    );

    spi_sequencer #(.N_CS(N_CS)) u_seq (
        .clk(clk), .rstn(rstn), .start(start), .xfer(xfer_q), .cs_mask(cs_mask_q),
        .done(done), .clk_en(clk_en), .fall(fall),
        .tx_load(tx_load), .tx_en(tx_en), .tx_word(tx_word), .tx_count(tx_count),
        .tx_need_word(tx_need_word), .tx_done(tx_done),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_load(rx_load), .rx_en(rx_en), .rx_count(rx_count),
        .rx_full(rx_full), .rx_done(rx_done),
        .quad(quad), .mode(mode), .csn(csn)
    );

    spi_clkgen #(.CLK_DIV_W(CLK_DIV_W)) u_clkgen (
        .clk(clk), .rstn(rstn), .en(clk_en), .clk_div(clk_div_q),
        .sclk(sclk), .rise(rise), .fall(fall)
    );

    spi_shift_tx u_tx (
        .clk(clk), .rstn(rstn), .en(tx_en), .fall(fall), .quad(quad),
        .load(tx_load), .load_word(tx_word), .bit_count(tx_count),
        .need_word(tx_need_word), .word_valid(tx_valid), .sdo(sdo), .done(tx_done)
    );

    spi_shift_rx u_rx (
        .clk(clk), .rstn(rstn), .en(rx_en), .rise(rise), .quad(quad),
        .load(rx_load), .bit_count(rx_count), .sdi(sdi),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .full(rx_full), .done(rx_done)
    );

    assign pad_out = '{sclk: sclk, sdo: sdo, mode: mode};

endmodule

`default_nettype wire

// ==== dv/spi_slave_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_slave_model #(
    parameter int N_CS      = 4,
    parameter int LOG_DEPTH = 8192
) (
    input  wire spi_pad_pkg::spi_pad_out_t pad_out,
    input  wire [N_CS-1:0]                 csn,
    output logic [3:0]                     sdi
);

    logic                   sclk;
    logic                   selected;
    logic [3:0]             sdo_log [0:LOG_DEPTH-1];    // lanes seen on each sclk rise
    logic [3:0]             sdi_log [0:LOG_DEPTH-1];    // lanes the master sampled
    spi_pad_pkg::spi_lane_e mode_log [0:LOG_DEPTH-1];
    int                     n_rise;

    assign sclk     = pad_out.sclk;
    assign selected = csn != '1;    // any select line low

    initial
    begin
        n_rise = 0;
        sdi    = 4'h0;
    end

    // sdo and sdi both hold still across a rising sclk edge
    always @(posedge sclk)
    begin
        if (selected && n_rise < LOG_DEPTH)
        begin
            sdo_log[n_rise]  = pad_out.sdo;
            sdi_log[n_rise]  = sdi;
            mode_log[n_rise] = pad_out.mode;
            n_rise           = n_rise + 1;
        end
    end

    always @(negedge sclk)
    begin
        if (selected)
            sdi <= 4'($urandom_range(0, 15));   // new bits on every lane
    end

endmodule

`default_nettype wire

// ==== dv/spi_master_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_master_tb;

    localparam int  CLK_DIV_W   = 8;
    localparam int  N_CS        = 4;
    localparam int  W           = spi_ctrl_pkg::WORD_W;
    localparam int  N_XFER      = 40;
    localparam int  MAX_BITS    = 160;      // 32 cmd, 32 addr, 96 data
    localparam real CLK_PERIOD  = 100.0;
    localparam real WATCHDOG_NS = (N_XFER * MAX_BITS * 8 + 2000) * CLK_PERIOD;

    logic                      clk;
    logic                      rstn;
    logic                      req;
    logic                      ack;
    spi_ctrl_pkg::spi_xfer_t   xfer;
    logic [CLK_DIV_W-1:0]      clk_div;
    logic [N_CS-1:0]           cs_mask;
    logic [W-1:0]              tx_data;
    logic                      tx_valid;
    logic                      tx_ready;
    logic [W-1:0]              rx_data;
    logic                      rx_valid;
    logic                      rx_ready;
    spi_pad_pkg::spi_pad_out_t pad_out;
    logic [N_CS-1:0]           csn;
    logic [3:0]                sdi;

    logic [W-1:0] tx_q[$];      // words still to offer on the tx stream
    logic [W-1:0] rx_got[$];
    bit           exp_bits[$];  // expected serial stream in send order
    logic         tx_moved;
    logic         cs_seen;
    int           high_cycles;
    int           n_errors;

    spi_master #(.CLK_DIV_W(CLK_DIV_W), .N_CS(N_CS)) dut (
        .clk(clk), .rstn(rstn), .req(req), .ack(ack),
        .xfer(xfer), .clk_div(clk_div), .cs_mask(cs_mask),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .pad_out(pad_out), .csn(csn), .sdi(sdi)
    );

    spi_slave_model #(.N_CS(N_CS)) slave (.pad_out(pad_out), .csn(csn), .sdi(sdi));

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = !clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: a transfer or a stream word never completed");
        $display("Checks failed");
        $finish;
    end

    task automatic report_fail(input string msg);
        n_errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    function automatic int pick_len(input int max_len, input int lanes, input bit may_skip);
        if (may_skip && $urandom_range(0, 3) == 0)
            return 0;
        return $urandom_range(1, max_len / lanes) * lanes;
    endfunction

    task automatic push_top_bits(input logic [W-1:0] word, input int n);
        for (int i = 0; i < n; i++)
            exp_bits.push_back(word[W-1-i]);
    endtask

    // a handshake seen at mid-cycle completes on the next edge
    always @(negedge clk)
    begin
        tx_moved = tx_valid && tx_ready;
        if (rx_valid && rx_ready)
            rx_got.push_back(rx_data);
        if (csn != '1)
        begin
            cs_seen = 1'b1;
            if (csn != ~cs_mask)
                report_fail($sformatf("csn %b with cs_mask %b", csn, cs_mask));
        end
        if (ack && csn != '1)
            report_fail($sformatf("ack high while csn is %b", csn));
        if (pad_out.sclk)
            high_cycles++;
        else if (high_cycles != 0)
        begin
            if (high_cycles != int'(clk_div) + 1)
                report_fail($sformatf("sclk high for %0d cycles, expected %0d",
                                      high_cycles, int'(clk_div) + 1));
            high_cycles = 0;
        end
    end

    always @(posedge clk)
    begin
        #1;
        if (tx_moved)
        begin
            tx_valid = 1'b0;
            void'(tx_q.pop_front());
        end
        if (!tx_valid && tx_q.size() != 0 && $urandom_range(0, 3) != 0)
        begin
            tx_data  = tx_q[0];
            tx_valid = 1'b1;
        end
        rx_ready = $urandom_range(0, 3) != 0;   // random gaps on both streams
    end

    task automatic run_transfer(input int idx);
        spi_ctrl_pkg::spi_xfer_t x;
        spi_pad_pkg::spi_lane_e  exp_mode;
        logic [CLK_DIV_W-1:0]    div;
        logic [N_CS-1:0]         mask;
        logic [W-1:0]            word;
        logic [W-1:0]            exp_words[$];
        logic [3:0]              exp_sdo;
        logic [3:0]              got_sdo;
        bit                      quad;
        bit                      rd;
        int                      lanes;
        int                      base;
        int                      n_pre;
        int                      rises_exp;
        int                      nbits;
        int                      hold;
        int                      errs_before;

        errs_before = n_errors;
        x.op        = spi_ctrl_pkg::spi_op_e'($urandom_range(0, 3));
        quad        = x.op == spi_ctrl_pkg::OP_QRD || x.op == spi_ctrl_pkg::OP_QWR;
        rd          = x.op == spi_ctrl_pkg::OP_RD || x.op == spi_ctrl_pkg::OP_QRD;
        lanes       = quad ? 4 : 1;
        x.cmd       = $urandom;
        x.addr      = $urandom;
        x.cmd_len   = 6'(pick_len(32, lanes, 1'b1));
        x.addr_len  = 6'(pick_len(32, lanes, 1'b1));
        x.data_len  = 16'(pick_len(96, lanes, 1'b0));
        div         = CLK_DIV_W'($urandom_range(0, 3));
        mask        = N_CS'($urandom_range(1, 15));

        exp_bits.delete();
        push_top_bits(x.cmd, int'(x.cmd_len));
        push_top_bits(x.addr, int'(x.addr_len));
        if (!rd)
        begin
            for (int w = 0; w * W < int'(x.data_len); w++)
            begin
                word  = $urandom;
                nbits = int'(x.data_len) - w * W;
                tx_q.push_back(word);
                push_top_bits(word, nbits > W ? W : nbits);
            end
        end

        base    = slave.n_rise;
        cs_seen = 1'b0;
        rx_got.delete();
        @(posedge clk);
        #1;
        xfer    = x;
        clk_div = div;
        cs_mask = mask;
        req     = 1'b1;
        while (ack !== 1'b1)
            @(negedge clk);
        hold = $urandom_range(0, 3);
        repeat (hold)
        begin
            @(negedge clk);
            if (ack !== 1'b1)
                report_fail("ack fell while req was still high");
        end
        @(posedge clk);
        #1;
        req = 1'b0;
        @(negedge clk);
        if (ack !== 1'b1)
            report_fail("ack fell before req fell");
        @(negedge clk);
        if (ack !== 1'b0)
            report_fail("ack still high one cycle after req fell");
        while (rd && rx_got.size() < (int'(x.data_len) + W - 1) / W)
            @(negedge clk);

        n_pre     = (int'(x.cmd_len) + int'(x.addr_len)) / lanes;
        rises_exp = (int'(x.cmd_len) + int'(x.addr_len) + int'(x.data_len)) / lanes;
        word      = '0;
        nbits     = 0;
        if (slave.n_rise - base != rises_exp)
            report_fail($sformatf("%0d sclk rises, expected %0d", slave.n_rise - base, rises_exp));
        else
        begin
            for (int r = 0; r < rises_exp; r++)
            begin
                if (!quad)
                    exp_mode = spi_pad_pkg::LANE_STD;
                else if (rd && r >= n_pre)
                    exp_mode = spi_pad_pkg::LANE_QUAD_RX;
                else
                    exp_mode = spi_pad_pkg::LANE_QUAD_TX;
                if (slave.mode_log[base + r] != exp_mode)
                    report_fail($sformatf("rise %0d mode %0d, expected %0d", r,
                                          slave.mode_log[base + r], exp_mode));
                if (!rd || r < n_pre)
                begin
                    got_sdo = slave.sdo_log[base + r];
                    if (quad)
                        exp_sdo = {exp_bits[4*r], exp_bits[4*r+1],
                                   exp_bits[4*r+2], exp_bits[4*r+3]};
                    else
                    begin
                        exp_sdo = {3'b000, exp_bits[r]};
                        got_sdo = {3'b000, got_sdo[0]};
                    end
                    if (got_sdo != exp_sdo)
                        report_fail($sformatf("rise %0d sdo %h, expected %h", r, got_sdo, exp_sdo));
                end
                else
                begin
                    if (quad)
                        word = {word[W-5:0], slave.sdi_log[base + r]};
                    else
                        word = {word[W-2:0], slave.sdi_log[base + r][1]};
                    nbits += lanes;
                    if (nbits == W)
                    begin
                        exp_words.push_back(word);
                        word  = '0;
                        nbits = 0;
                    end
                end
            end
        end
        if (nbits != 0)
            exp_words.push_back(word);      // partial word stays right-aligned

        if (rx_got.size() != exp_words.size())
            report_fail($sformatf("%0d rx words, expected %0d", rx_got.size(), exp_words.size()));
        else
        begin
            for (int i = 0; i < exp_words.size(); i++)
                if (rx_got[i] != exp_words[i])
                    report_fail($sformatf("rx word %0d is %h, expected %h", i, rx_got[i],
                                          exp_words[i]));
        end
        if (tx_q.size() != 0)
            report_fail($sformatf("%0d tx words never taken", tx_q.size()));
        if (!cs_seen)
            report_fail("no chip select went low during the transfer");
        $display("test %0d: op %0d cmd %0d addr %0d data %0d div %0d mask %b: %s", idx, x.op,
                 x.cmd_len, x.addr_len, x.data_len, div, mask,
                 n_errors == errs_before ? "ok" : "mismatch");
    endtask

    initial
    begin : main
        void'($urandom(32'h6423_baf3));
        n_errors    = 0;
        high_cycles = 0;
        tx_moved    = 1'b0;
        cs_seen     = 1'b0;
        rstn        = 1'b0;
        req         = 1'b0;
        xfer        = '0;
        clk_div     = '0;
        cs_mask     = '0;
        tx_data     = '0;
        tx_valid    = 1'b0;
        rx_ready    = 1'b0;

        repeat (4)
            @(negedge clk);
        if (ack !== 1'b0 || tx_ready !== 1'b0 || rx_valid !== 1'b0)
            report_fail("ack, tx_ready or rx_valid not low in reset");
        if (csn !== '1)
            report_fail($sformatf("csn %b in reset", csn));
        if (pad_out.sclk !== 1'b0 || pad_out.mode !== spi_pad_pkg::LANE_QUAD_RX)
            report_fail("sclk or lane mode wrong in reset");
        $display("test 0: reset values: %s", n_errors == 0 ? "ok" : "mismatch");
        repeat (4)
            @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int t = 1; t <= N_XFER; t++)
            run_transfer(t);

        $display("%0d tests run, %0d errors", N_XFER + 1, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/spi_ctrl_pkg.sv
hdl/spi_pad_pkg.sv
hdl/spi_xfer_regs.sv
hdl/spi_clkgen.sv
hdl/spi_shift_tx.sv
hdl/spi_shift_rx.sv
hdl/spi_sequencer.sv
hdl/spi_master.sv
dv/spi_slave_model.sv
dv/spi_master_tb.sv
